// ==== logic/ramio_pkg.sv ====
/*
  shared definitions for the memory-mapped I/O bridge
  read and write access kinds, serial frame phases
  data and address widths, RAM depth, I/O address map, UART bit timing
*/
`default_nettype none

package ramio_pkg;

  // client bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // on-chip RAM depth in words, 2**10 = 1024
  localparam int RAM_WORDS_LOG2 = 10;

  // I/O registers sit in the top three words of the address space
  // led nibble is low-active, 1 = led off
  localparam logic [ADDR_W-1:0] ADDR_LED      = {ADDR_W{1'b1}} - 3;
  localparam logic [ADDR_W-1:0] ADDR_UART_OUT = {ADDR_W{1'b1}} - 7;
  localparam logic [ADDR_W-1:0] ADDR_UART_IN  = {ADDR_W{1'b1}} - 11;

  // value of an idle transmitter or an empty receiver
  localparam logic [DATA_W-1:0] UART_IDLE = '1;

  // serial bit period in clocks, small to keep simulation short
  localparam int CLKS_PER_BIT = 16;
  localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // bit 2 selects sign extension, low bits give the size
  typedef enum logic [2:0] {
    rd_none   = 3'b000,
    rd_byte_u = 3'b001,
    rd_half_u = 3'b010,
    rd_word   = 3'b111,
    rd_byte_s = 3'b101,
    rd_half_s = 3'b110
  } read_type_e;

  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_byte = 2'b01,
    wr_half = 2'b10,
    wr_word = 2'b11
  } write_type_e;

  // phase of an 8N1 frame
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } uart_state_e;

endpackage

`default_nettype wire

// ==== logic/ram_port_if.sv ====
/*
  word access port between the bridge and the on-chip RAM
  master and slave modports
*/
`timescale 1ns/10ps
`default_nettype none

interface ram_port_if;

  // one access per cycle, zero wstrb means read
  logic                                en;
  logic [ramio_pkg::RAM_WORDS_LOG2-1:0] word_addr;
  logic [31:0]                         wdata;
  logic [3:0]                          wstrb;
  // read data, valid one cycle after the access
  logic [31:0]                         rdata;
  logic                                rvalid;

  modport master (output en, word_addr, wdata, wstrb, input rdata, rvalid);
  modport slave  (input en, word_addr, wdata, wstrb, output rdata, rvalid);

endinterface

`default_nettype wire

// ==== logic/word_ram.sv ====
/*
  single-port word RAM
  byte-lane write enables, registered read with valid strobe
*/
`timescale 1ns/10ps
`default_nettype none

module word_ram (
  input wire         clk,
  ram_port_if.slave  ram
);

  localparam int DEPTH = 2 ** ramio_pkg::RAM_WORDS_LOG2;

  logic [31:0] mem [0:DEPTH-1];

  // write enabled lanes, read the old word (read-first)
  always_ff @(posedge clk) begin
    if (ram.en) begin
      for (int i = 0; i < 4; i++) begin
        if (ram.wstrb[i]) begin
          mem[ram.word_addr][8*i +: 8] <= ram.wdata[8*i +: 8];
        end
      end
      ram.rdata <= mem[ram.word_addr];
    end
  end

  // valid only for reads, one cycle behind en
  always_ff @(posedge clk) begin
    ram.rvalid <= ram.en && (ram.wstrb == 4'b0000);
  end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
/*
  8N1 serial transmitter
  start strobe in, busy level out, lsb first
*/
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        tx_start_i,
  input  wire  [7:0] tx_byte_i,
  output logic       tx_busy_o,
  output logic       tx_o
);

  localparam logic [ramio_pkg::BIT_CNT_W-1:0] BIT_LAST =
    ramio_pkg::BIT_CNT_W'(ramio_pkg::CLKS_PER_BIT - 1);

  ramio_pkg::uart_state_e      state_q;
  logic [ramio_pkg::BIT_CNT_W-1:0] cnt_q;
  logic [2:0]                  bit_q;
  logic [7:0]                  shift_q;
  logic                        tx_q;

  // counter at zero ends the current bit period
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ramio_pkg::st_idle;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else begin
      case (state_q)
        ramio_pkg::st_idle: begin
          // a start while busy never reaches here, so it is dropped
          if (tx_start_i) begin
            state_q <= ramio_pkg::st_start;
            cnt_q   <= BIT_LAST;
            tx_q    <= 1'b0;
            shift_q <= tx_byte_i;
          end
        end
        ramio_pkg::st_start: begin
          if (cnt_q == '0) begin
            state_q <= ramio_pkg::st_data;
            cnt_q   <= BIT_LAST;
            bit_q   <= '0;
            tx_q    <= shift_q[0];
            shift_q <= shift_q >> 1;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ramio_pkg::st_data: begin
          if (cnt_q == '0) begin
            cnt_q <= BIT_LAST;
            if (bit_q == 3'd7) begin
              // stop bit
              state_q <= ramio_pkg::st_stop;
              tx_q    <= 1'b1;
            end else begin
              bit_q   <= bit_q + 1'b1;
              tx_q    <= shift_q[0];
              shift_q <= shift_q >> 1;
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          // end of stop bit closes the frame
          if (cnt_q == '0) begin
            state_q <= ramio_pkg::st_idle;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
      endcase
    end
  end

  assign tx_busy_o = (state_q != ramio_pkg::st_idle);
  assign tx_o      = tx_q;

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
/*
  8N1 serial receiver
  two-flop line sync, start edge detect, mid-bit sampling
  one-cycle valid strobe per good frame
*/
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_byte_o
);

  localparam logic [ramio_pkg::BIT_CNT_W-1:0] BIT_LAST =
    ramio_pkg::BIT_CNT_W'(ramio_pkg::CLKS_PER_BIT - 1);
  localparam logic [ramio_pkg::BIT_CNT_W-1:0] HALF_LAST =
    ramio_pkg::BIT_CNT_W'(ramio_pkg::CLKS_PER_BIT / 2 - 1);

  ramio_pkg::uart_state_e      state_q;
  logic [ramio_pkg::BIT_CNT_W-1:0] cnt_q;
  logic [2:0]                  bit_q;
  logic [7:0]                  shift_q;
  // sync chain, rx_s3 is the previous synced sample
  logic                        rx_s1;
  logic                        rx_s2;
  logic                        rx_s3;
  logic                        frame_ok;

  // mid stop bit with the line high
  assign frame_ok = (state_q == ramio_pkg::st_stop) && (cnt_q == '0) && rx_s2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_s1      <= 1'b1;
      rx_s2      <= 1'b1;
      rx_s3      <= 1'b1;
      state_q    <= ramio_pkg::st_idle;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_s1      <= rx_i;
      rx_s2      <= rx_s1;
      rx_s3      <= rx_s2;
      rx_valid_o <= frame_ok;
      case (state_q)
        ramio_pkg::st_idle: begin
          // falling edge, wait half a bit
          if (rx_s3 && !rx_s2) begin
            state_q <= ramio_pkg::st_start;
            cnt_q   <= HALF_LAST;
          end
        end
        ramio_pkg::st_start: begin
          if (cnt_q == '0) begin
            // glitch if the line is high again at mid start bit
            state_q <= rx_s2 ? ramio_pkg::st_idle : ramio_pkg::st_data;
            cnt_q   <= BIT_LAST;
            bit_q   <= '0;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        ramio_pkg::st_data: begin
          if (cnt_q == '0) begin
            // lsb arrives first, shift in from the top
            shift_q <= {rx_s2, shift_q[7:1]};
            cnt_q   <= BIT_LAST;
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= ramio_pkg::st_stop;
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          // bad stop bit drops the frame
          if (cnt_q == '0) begin
            state_q <= ramio_pkg::st_idle;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
      endcase
    end
  end

  // received byte, held until the next good frame
  always_ff @(posedge clk) begin
    if (frame_ok) begin
      rx_byte_o <= shift_q;
    end
  end

endmodule

`default_nettype wire

// ==== logic/ramio.sv ====
/*
  client access bridge
  I/O address decode, byte-lane steering to the word RAM
  read lane select and sign/zero extension
  LED, UART send and UART receive registers
*/
`timescale 1ns/10ps
`default_nettype none

module ramio (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              enable_i,
  input  ramio_pkg::read_type_e            read_type_i,
  input  ramio_pkg::write_type_e           write_type_i,
  input  wire  [ramio_pkg::ADDR_W-1:0]     address_i,
  input  wire  [ramio_pkg::DATA_W-1:0]     data_i,
  output logic [ramio_pkg::DATA_W-1:0]     data_o,
  output logic                             data_ready_o,
  output logic [3:0]                       led_o,
  ram_port_if.master                       ram,
  output logic                             tx_start_o,
  output logic [7:0]                       tx_byte_o,
  input  wire                              tx_busy_i,
  input  wire                              rx_valid_i,
  input  wire  [7:0]                       rx_byte_i
);

  logic                          is_io;
  logic                          is_rd;
  logic                          is_wr;
  logic                          is_half;
  logic                          is_word;
  logic                          misaligned;
  logic                          rd_io;
  // read pipeline
  logic                          io_rd_q;
  logic                          ram_rd_q;
  logic                          misal_q;
  logic [1:0]                    lane_q;
  ramio_pkg::read_type_e         rtype_q;
  logic [ramio_pkg::DATA_W-1:0]  io_rdata_q;
  logic [ramio_pkg::DATA_W-1:0]  ram_ext;
  logic [7:0]                    rd_byte;
  logic [15:0]                   rd_half;
  // I/O registers
  logic [3:0]                    led_q;
  logic [7:0]                    tx_data_q;
  logic                          tx_start_q;
  logic [ramio_pkg::DATA_W-1:0]  tx_reg;
  logic [ramio_pkg::DATA_W-1:0]  rx_reg_q;

  assign is_io = address_i inside {ramio_pkg::ADDR_LED, ramio_pkg::ADDR_UART_OUT,
                                   ramio_pkg::ADDR_UART_IN};
  assign is_rd = enable_i && (read_type_i != ramio_pkg::rd_none);
  assign is_wr = enable_i && (write_type_i != ramio_pkg::wr_none);

  // access size from whichever kind is requested
  assign is_half = (write_type_i == ramio_pkg::wr_half) ||
                   (read_type_i == ramio_pkg::rd_half_u) ||
                   (read_type_i == ramio_pkg::rd_half_s);
  assign is_word = (write_type_i == ramio_pkg::wr_word) ||
                   (read_type_i == ramio_pkg::rd_word);
  assign misaligned = (is_half && address_i[0]) || (is_word && (address_i[1:0] != 2'b00));

  // RAM side, I/O and misaligned writes never reach it
  // misaligned reads still go out so the result comes back on rvalid
  assign ram.en        = enable_i && !is_io && !(is_wr && misaligned);
  assign ram.word_addr = address_i[ramio_pkg::RAM_WORDS_LOG2+1:2];

  always_comb begin
    ram.wstrb = 4'b0000;
    ram.wdata = data_i;
    if (is_wr && !misaligned) begin
      case (write_type_i)
        ramio_pkg::wr_byte: begin
          // replicate the byte, strobe picks the lane
          ram.wstrb = 4'b0001 << address_i[1:0];
          ram.wdata = {4{data_i[7:0]}};
        end
        ramio_pkg::wr_half: begin
          ram.wstrb = address_i[1] ? 4'b1100 : 4'b0011;
          ram.wdata = {2{data_i[15:0]}};
        end
        ramio_pkg::wr_word: begin
          ram.wstrb = 4'b1111;
        end
        default: begin
          ram.wstrb = 4'b0000;
        end
      endcase
    end
  end

  // read pipeline control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      io_rd_q  <= 1'b0;
      ram_rd_q <= 1'b0;
    end else begin
      io_rd_q  <= is_rd && is_io;
      ram_rd_q <= is_rd && !is_io;
    end
  end

  // access details travel with the read
  always_ff @(posedge clk) begin
    lane_q  <= address_i[1:0];
    rtype_q <= read_type_i;
    misal_q <= misaligned;
  end

  // lane select from the returning word
  assign rd_byte = ram.rdata[8*lane_q +: 8];
  assign rd_half = lane_q[1] ? ram.rdata[31:16] : ram.rdata[15:0];

  always_comb begin
    case (rtype_q)
      ramio_pkg::rd_byte_u,
      ramio_pkg::rd_byte_s: ram_ext = {{24{rtype_q[2] & rd_byte[7]}}, rd_byte};
      ramio_pkg::rd_half_u,
      ramio_pkg::rd_half_s: ram_ext = {{16{rtype_q[2] & rd_half[15]}}, rd_half};
      ramio_pkg::rd_word:   ram_ext = ram.rdata;
      default:              ram_ext = '0;
    endcase
    // misaligned reads give zero
    if (misal_q) begin
      ram_ext = '0;
    end
  end

  assign data_o       = io_rd_q ? io_rdata_q : ram_ext;
  assign data_ready_o = io_rd_q || (ram_rd_q && ram.rvalid);

  // uart send, start strobe straight from the write
  assign tx_start_o = is_wr && (address_i == ramio_pkg::ADDR_UART_OUT);
  assign tx_byte_o  = data_i[7:0];
  assign rd_io      = is_rd && (address_i == ramio_pkg::ADDR_UART_IN);

  // send register shows the byte while the frame is going out
  assign tx_reg = (tx_busy_i || tx_start_q) ? {24'h0, tx_data_q} : ramio_pkg::UART_IDLE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_q      <= 4'b1111;
      tx_start_q <= 1'b0;
      rx_reg_q   <= ramio_pkg::UART_IDLE;
    end else begin
      tx_start_q <= tx_start_o && !tx_busy_i;
      if (is_wr && (address_i == ramio_pkg::ADDR_LED)) begin
        led_q <= data_i[3:0];
      end
      // a read empties the register even if a byte lands this cycle
      if (rd_io) begin
        rx_reg_q <= ramio_pkg::UART_IDLE;
      end else if (rx_valid_i) begin
        rx_reg_q <= {24'h0, rx_byte_i};
      end
    end
  end

  // byte only kept when the transmitter takes it
  always_ff @(posedge clk) begin
    if (tx_start_o && !tx_busy_i) begin
      tx_data_q <= data_i[7:0];
    end
  end

  // I/O read data captured at the request edge
  always_ff @(posedge clk) begin
    case (address_i)
      ramio_pkg::ADDR_LED:      io_rdata_q <= {28'h0, led_q};
      ramio_pkg::ADDR_UART_OUT: io_rdata_q <= tx_reg;
      ramio_pkg::ADDR_UART_IN:  io_rdata_q <= rx_reg_q;
      default:                  io_rdata_q <= '0;
    endcase
  end

  assign led_o = led_q;

endmodule

`default_nettype wire

// ==== logic/ramio_top.sv ====
/*
  top level of the I/O bridge system
  bridge, word RAM, UART transmitter and receiver
*/
`timescale 1ns/10ps
`default_nettype none

module ramio_top (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              enable_i,
  input  ramio_pkg::read_type_e            read_type_i,
  input  ramio_pkg::write_type_e           write_type_i,
  input  wire  [ramio_pkg::ADDR_W-1:0]     address_i,
  input  wire  [ramio_pkg::DATA_W-1:0]     data_i,
  output logic [ramio_pkg::DATA_W-1:0]     data_o,
  output logic                             data_ready_o,
  output logic [3:0]                       led_o,
  output logic                             uart_tx_o,
  input  wire                              uart_rx_i
);

  // uart side wires
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       rx_valid;
  logic [7:0] rx_byte;

  ram_port_if i_ram_port ();

  ramio i_ramio (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .read_type_i  (read_type_i),
    .write_type_i (write_type_i),
    .address_i    (address_i),
    .data_i       (data_i),
    .data_o       (data_o),
    .data_ready_o (data_ready_o),
    .led_o        (led_o),
    .ram          (i_ram_port.master),
    .tx_start_o   (tx_start),
    .tx_byte_o    (tx_byte),
    .tx_busy_i    (tx_busy),
    .rx_valid_i   (rx_valid),
    .rx_byte_i    (rx_byte)
  );

  word_ram i_word_ram (
    .clk (clk),
    .ram (i_ram_port.slave)
  );

  uart_tx i_uart_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .tx_busy_o  (tx_busy),
    .tx_o       (uart_tx_o)
  );

  uart_rx i_uart_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

endmodule

`default_nettype wire

// ==== test/ramio_checker.sv ====
/*
  bound assertions for the I/O bridge top level
  read ready timing, LED register updates, serial line idle level
*/
`timescale 1ns/10ps
`default_nettype none

module ramio_checker (
  input wire                          clk,
  input wire                          rst_n,
  input wire                          enable_i,
  input ramio_pkg::read_type_e        read_type_i,
  input ramio_pkg::write_type_e       write_type_i,
  input wire [ramio_pkg::ADDR_W-1:0]  address_i,
  input wire                          data_ready_i,
  input wire [3:0]                    led_i,
  input wire                          uart_tx_i,
  input wire                          tx_busy_i
);

  logic rd_req;
  logic led_wr;

  assign rd_req = enable_i && (read_type_i != ramio_pkg::rd_none);
  assign led_wr = enable_i && (write_type_i != ramio_pkg::wr_none) &&
                  (address_i == ramio_pkg::ADDR_LED);

  // every read answers on the next cycle, ram and I/O alike
  read_ready_a: assert property (@(posedge clk) disable iff (!rst_n) rd_req |=> data_ready_i)
    else $error("data_ready_o missing one cycle after a read request");

  // and no ready strobe without a read one cycle earlier
  ready_cause_a: assert property (@(posedge clk) disable iff (!rst_n)
    data_ready_i |-> $past(rd_req))
    else $error("data_ready_o high without a read request one cycle earlier");

  // led nibble only moves on a write to its register
  led_write_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(led_i) |-> $past(led_wr))
    else $error("led_o changed without a write to the LED register");

  // line rests high between frames
  tx_idle_a: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy_i |-> uart_tx_i)
    else $error("uart_tx_o low while the transmitter is idle");

endmodule

bind ramio_top ramio_checker i_ramio_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .enable_i     (enable_i),
  .read_type_i  (read_type_i),
  .write_type_i (write_type_i),
  .address_i    (address_i),
  .data_ready_i (data_ready_o),
  .led_i        (led_o),
  .uart_tx_i    (uart_tx_o),
  .tx_busy_i    (tx_busy)
);

`default_nettype wire

// ==== test/ramio_tb.sv ====
/*
  testbench for the I/O bridge system
  clock, reset, falling-edge stimulus, shadow memory reference model
  read compare process, LED and UART register tests with loopback
*/
`timescale 1ns/10ps
`default_nettype none

module ramio_tb;

  // bound on every wait, in cycles or poll reads
  localparam int TIMEOUT = 40 * ramio_pkg::CLKS_PER_BIT;

  logic                           clk;
  logic                           rst_n;
  logic                           enable_i;
  ramio_pkg::read_type_e          read_type_i;
  ramio_pkg::write_type_e         write_type_i;
  logic [ramio_pkg::ADDR_W-1:0]   address_i;
  logic [ramio_pkg::DATA_W-1:0]   data_i;
  logic [ramio_pkg::DATA_W-1:0]   data_o;
  logic                           data_ready_o;
  logic [3:0]                     led_o;
  wire                            loopback;

  // reference model, one shadow word per RAM word
  logic [31:0]                    shadow [0:1023];
  logic [ramio_pkg::DATA_W-1:0]   exp_q [$];
  ramio_pkg::read_type_e          exp_type_q [$];
  logic [31:0]                    rng;
  int                             errors;
  int                             checks;
  int                             test_num;
  int                             test_err_start;
  // reads whose value the test inspects itself
  logic                           polling;
  int                             poll_seen;
  logic [ramio_pkg::DATA_W-1:0]   poll_data;
  logic [7:0]                     sent_byte;

  ramio_top i_ramio_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .read_type_i  (read_type_i),
    .write_type_i (write_type_i),
    .address_i    (address_i),
    .data_i       (data_i),
    .data_o       (data_o),
    .data_ready_o (data_ready_o),
    .led_o        (led_o),
    .uart_tx_o    (loopback),
    .uart_rx_i    (loopback)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected read value from the stored word
  function automatic logic [31:0] ref_read(input logic [31:0] word, input logic [31:0] addr,
                                           input ramio_pkg::read_type_e rt);
    logic [31:0] sh;
    logic [1:0]  off;
    off = addr[1:0];
    sh  = word >> (8 * off);
    case (rt)
      ramio_pkg::rd_byte_u: return {24'h0, sh[7:0]};
      ramio_pkg::rd_byte_s: return {{24{sh[7]}}, sh[7:0]};
      ramio_pkg::rd_half_u: return off[0] ? 32'h0 : {16'h0, sh[15:0]};
      ramio_pkg::rd_half_s: return off[0] ? 32'h0 : {{16{sh[15]}}, sh[15:0]};
      ramio_pkg::rd_word:   return (off != 2'b00) ? 32'h0 : word;
      default:              return 32'h0;
    endcase
  endfunction

  // stored word after a write, misaligned half and word writes dropped
  function automatic logic [31:0] ref_write(input logic [31:0] old, input logic [31:0] addr,
                                            input ramio_pkg::write_type_e wt,
                                            input logic [31:0] data);
    logic [31:0] w;
    logic [1:0]  off;
    w   = old;
    off = addr[1:0];
    case (wt)
      ramio_pkg::wr_byte: w[8*off +: 8] = data[7:0];
      ramio_pkg::wr_half: begin
        if (!off[0]) begin
          w[8*off +: 16] = data[15:0];
        end
      end
      ramio_pkg::wr_word: begin
        if (off == 2'b00) begin
          w = data;
        end
      end
      default: w = old;
    endcase
    return w;
  endfunction

  task automatic check_data(input logic [ramio_pkg::DATA_W-1:0] got,
                            input logic [ramio_pkg::DATA_W-1:0] exp,
                            input ramio_pkg::read_type_e rt);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s read returned %h, expected %h", $time, rt.name(), got, exp);
    end
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: led_o is %b, expected %b", $time, got, exp);
    end
  endtask

  // compare each returned read with the oldest expectation
  always @(negedge clk) begin
    if (rst_n && data_ready_o) begin
      if (exp_q.size() != 0) begin
        check_data(data_o, exp_q.pop_front(), exp_type_q.pop_front());
      end else if (polling) begin
        poll_data = data_o;
        poll_seen++;
      end else begin
        errors++;
        $display("unexpected data_ready_o at %0t ns with no read pending", $time);
      end
    end
  end

  task automatic drive(input ramio_pkg::read_type_e rt, input ramio_pkg::write_type_e wt,
                       input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    enable_i     = 1'b1;
    read_type_i  = rt;
    write_type_i = wt;
    address_i    = addr;
    data_i       = data;
  endtask

  task automatic idle();
    @(negedge clk);
    enable_i     = 1'b0;
    read_type_i  = ramio_pkg::rd_none;
    write_type_i = ramio_pkg::wr_none;
  endtask

  task automatic ram_write(input logic [31:0] addr, input ramio_pkg::write_type_e wt,
                           input logic [31:0] data);
    drive(ramio_pkg::rd_none, wt, addr, data);
    shadow[addr[11:2]] = ref_write(shadow[addr[11:2]], addr, wt, data);
  endtask

  task automatic ram_read(input logic [31:0] addr, input ramio_pkg::read_type_e rt);
    drive(rt, ramio_pkg::wr_none, addr, 32'h0);
    exp_q.push_back(ref_read(shadow[addr[11:2]], addr, rt));
    exp_type_q.push_back(rt);
  endtask

  // I/O registers ignore the read kind and return the whole register
  task automatic io_read(input logic [31:0] addr, input logic [31:0] exp);
    drive(ramio_pkg::rd_word, ramio_pkg::wr_none, addr, 32'h0);
    exp_q.push_back(exp);
    exp_type_q.push_back(ramio_pkg::rd_word);
  endtask

  // wait until every queued read has come back
  task automatic drain();
    int n;
    idle();
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: %0d reads never raised data_ready_o", exp_q.size());
      exp_q.delete();
      exp_type_q.delete();
    end
  endtask

  task automatic poll_read(input logic [31:0] addr, output logic [31:0] data, output logic ok);
    int start;
    int n;
    polling = 1'b1;
    start   = poll_seen;
    drive(ramio_pkg::rd_word, ramio_pkg::wr_none, addr, 32'h0);
    idle();
    n = 0;
    while (poll_seen == start && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok      = (poll_seen != start);
    data    = poll_data;
    polling = 1'b0;
  endtask

  // send register shows the byte until the frame is out
  task automatic wait_tx_idle(input logic [7:0] b);
    logic [31:0] d;
    logic        ok;
    logic        done;
    done = 1'b0;
    for (int i = 0; i < TIMEOUT && !done; i++) begin
      poll_read(ramio_pkg::ADDR_UART_OUT, d, ok);
      if (!ok) begin
        errors++;
        $display("timeout: poll read of the UART send register got no data_ready_o");
        done = 1'b1;
      end else if (d == ramio_pkg::UART_IDLE) begin
        done = 1'b1;
      end else begin
        check_data(d, {24'h0, b}, ramio_pkg::rd_word);
      end
    end
    if (!done) begin
      errors++;
      $display("timeout: UART send register never returned to idle");
    end
  endtask

  task automatic start_test();
    test_num++;
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d errors", test_num, name, errors - test_err_start);
  endtask

  task automatic word_write_read();
    logic [31:0] addrs [16];
    start_test();
    for (int i = 0; i < 16; i++) begin
      rng = xorshift(rng);
      addrs[i] = {20'h0, rng[11:2], 2'b00};
      rng = xorshift(rng);
      ram_write(addrs[i], ramio_pkg::wr_word, rng);
    end
    // reads go out back to back
    for (int i = 0; i < 16; i++) begin
      ram_read(addrs[i], ramio_pkg::rd_word);
    end
    drain();
    end_test("word write and read back");
  endtask

  task automatic sub_word_merge();
    logic [31:0] base;
    start_test();
    for (int r = 0; r < 4; r++) begin
      rng = xorshift(rng);
      base = {20'h0, rng[11:2], 2'b00};
      rng = xorshift(rng);
      ram_write(base, ramio_pkg::wr_word, rng);
      // negative upper half, then random bytes over lanes 1 and 3
      rng = xorshift(rng);
      ram_write(base + 2, ramio_pkg::wr_half, rng | 32'h8000);
      rng = xorshift(rng);
      ram_write(base + 1, ramio_pkg::wr_byte, rng);
      // lane 3 byte keeps the upper half negative
      rng = xorshift(rng);
      ram_write(base + 3, ramio_pkg::wr_byte, rng | 32'h80);
      for (int l = 0; l < 4; l++) begin
        ram_read(base + l, ramio_pkg::rd_byte_u);
        ram_read(base + l, ramio_pkg::rd_byte_s);
      end
      ram_read(base, ramio_pkg::rd_half_u);
      ram_read(base, ramio_pkg::rd_half_s);
      ram_read(base + 2, ramio_pkg::rd_half_u);
      ram_read(base + 2, ramio_pkg::rd_half_s);
      ram_read(base, ramio_pkg::rd_word);
    end
    drain();
    end_test("byte and half-word merge and extension");
  endtask

  task automatic misaligned_access();
    logic [31:0] base;
    start_test();
    rng = xorshift(rng);
    base = {20'h0, rng[11:2], 2'b00};
    rng = xorshift(rng);
    ram_write(base, ramio_pkg::wr_word, rng);
    rng = xorshift(rng);
    ram_write(base + 1, ramio_pkg::wr_half, rng);
    ram_write(base + 3, ramio_pkg::wr_half, ~rng);
    rng = xorshift(rng);
    ram_write(base + 2, ramio_pkg::wr_word, rng);
    ram_write(base + 1, ramio_pkg::wr_word, ~rng);
    ram_read(base, ramio_pkg::rd_word);
    ram_read(base + 1, ramio_pkg::rd_half_s);
    ram_read(base + 3, ramio_pkg::rd_half_u);
    ram_read(base + 2, ramio_pkg::rd_word);
    ram_read(base + 3, ramio_pkg::rd_word);
    drain();
    end_test("misaligned accesses");
  endtask

  task automatic led_register();
    logic [3:0] n;
    start_test();
    // all leds off out of reset
    check_led(led_o, 4'hf);
    for (int i = 0; i < 3; i++) begin
      rng = xorshift(rng);
      n = rng[3:0];
      drive(ramio_pkg::rd_none, ramio_pkg::wr_word, ramio_pkg::ADDR_LED, {rng[31:4], n});
      idle();
      check_led(led_o, n);
      io_read(ramio_pkg::ADDR_LED, {28'h0, n});
      drain();
    end
    end_test("LED register");
  endtask

  task automatic uart_send();
    start_test();
    io_read(ramio_pkg::ADDR_UART_OUT, ramio_pkg::UART_IDLE);
    rng = xorshift(rng);
    sent_byte = rng[7:0];
    drive(ramio_pkg::rd_none, ramio_pkg::wr_word, ramio_pkg::ADDR_UART_OUT, {24'h0, sent_byte});
    // byte visible on the very next read
    io_read(ramio_pkg::ADDR_UART_OUT, {24'h0, sent_byte});
    drain();
    wait_tx_idle(sent_byte);
    end_test("UART send register");
  endtask

  // poll the receive register until the looped-back byte lands
  task automatic uart_loopback();
    logic [31:0] d;
    logic        ok;
    logic        done;
    int          n;
    start_test();
    done = 1'b0;
    n    = 0;
    while (!done && n < TIMEOUT) begin
      poll_read(ramio_pkg::ADDR_UART_IN, d, ok);
      n++;
      if (!ok) begin
        errors++;
        $display("timeout: poll read of the UART receive register got no data_ready_o");
        done = 1'b1;
      end else if (d != ramio_pkg::UART_IDLE) begin
        check_data(d, {24'h0, sent_byte}, ramio_pkg::rd_word);
        done = 1'b1;
      end
    end
    if (!done) begin
      errors++;
      $display("timeout: no byte arrived in the UART receive register");
    end
    // the read above emptied the register
    io_read(ramio_pkg::ADDR_UART_IN, ramio_pkg::UART_IDLE);
    drain();
    end_test("UART receive through loopback");
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    enable_i     = 1'b0;
    read_type_i  = ramio_pkg::rd_none;
    write_type_i = ramio_pkg::wr_none;
    address_i    = '0;
    data_i       = '0;
    rng          = 32'h3caa_0722;
    errors       = 0;
    checks       = 0;
    test_num     = 0;
    polling      = 1'b0;
    poll_seen    = 0;
    poll_data    = '0;
    sent_byte    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    word_write_read();
    sub_word_merge();
    misaligned_access();
    led_register();
    uart_send();
    uart_loopback();
    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ramio_sys.f ====
logic/ramio_pkg.sv
logic/ram_port_if.sv
logic/word_ram.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/ramio.sv
logic/ramio_top.sv
test/ramio_checker.sv
test/ramio_tb.sv

// ==== run_ramio_sys.sh ====
#!/bin/sh
# compile and run the ramio_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ramio_tb -f ramio_sys.f

# simulator output goes to the log, pass is decided by searching it
./obj_dir/Vramio_tb | tee sim.log
grep -q "All tests passed" sim.log
